// ==== logic/csr_access_if.sv ====
// Carries one access per cycle; wr_en is only high for accepted writes
`timescale 1ns/1ns
`default_nettype none

interface csr_access_if;

    logic                          wr_en;
    logic [csr_pkg::sel_bits-1:0]  sel;
    logic [csr_pkg::wid_bits-1:0]  wid;
    logic [csr_pkg::xlen-1:0]      wdata;

    modport decode (
        output wr_en,
        output sel,
        output wid,
        output wdata
    );

    // Register state only acts on write strobes
    modport state (
        input wr_en,
        input sel,
        input wid,
        input wdata
    );

    // Read side needs the register and the requesting warp
    modport read (
        input sel,
        input wid
    );

endinterface

`default_nettype wire

// ==== logic/csr_addr_decode.sv ====
// Zero-wait APB only; a write is accepted only in an access cycle after a setup cycle
`timescale 1ns/1ns
`default_nettype none

module csr_addr_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [csr_pkg::addr_bits-1:0] paddr,
    input  logic [csr_pkg::xlen-1:0]      pwdata,
    input  logic [csr_pkg::wid_bits-1:0]  pwid,
    output logic                          pready,
    output logic                          pslverr,
    csr_access_if.decode                  acc
);

    logic [csr_pkg::sel_bits-1:0] sel_dec;
    logic                         writable;
    logic                         access;
    logic                         reject;
    logic                         setup_q;

    always_comb begin
        sel_dec  = csr_pkg::sel_none;
        writable = 1'b0;
        case (paddr)
            csr_pkg::csr_fflags: begin
                sel_dec  = csr_pkg::sel_fflags;
                writable = 1'b1;
            end
            csr_pkg::csr_frm: begin
                sel_dec  = csr_pkg::sel_frm;
                writable = 1'b1;
            end
            csr_pkg::csr_fcsr: begin
                sel_dec  = csr_pkg::sel_fcsr;
                writable = 1'b1;
            end
            csr_pkg::csr_mscratch: begin
                sel_dec  = csr_pkg::sel_mscratch;
                writable = 1'b1;
            end
            csr_pkg::csr_mvendorid:      sel_dec = csr_pkg::sel_mvendorid;
            csr_pkg::csr_marchid:        sel_dec = csr_pkg::sel_marchid;
            csr_pkg::csr_mimpid:         sel_dec = csr_pkg::sel_mimpid;
            csr_pkg::csr_misa:           sel_dec = csr_pkg::sel_misa;
            csr_pkg::csr_warp_id:        sel_dec = csr_pkg::sel_warp_id;
            csr_pkg::csr_core_id:        sel_dec = csr_pkg::sel_core_id;
            csr_pkg::csr_active_threads: sel_dec = csr_pkg::sel_active_threads;
            csr_pkg::csr_active_warps:   sel_dec = csr_pkg::sel_active_warps;
            csr_pkg::csr_num_threads:    sel_dec = csr_pkg::sel_num_threads;
            csr_pkg::csr_num_warps:      sel_dec = csr_pkg::sel_num_warps;
            csr_pkg::csr_mcycle:         sel_dec = csr_pkg::sel_cycle_lo;
            csr_pkg::csr_mcycleh:        sel_dec = csr_pkg::sel_cycle_hi;
            csr_pkg::csr_minstret:       sel_dec = csr_pkg::sel_instret_lo;
            csr_pkg::csr_minstreth:      sel_dec = csr_pkg::sel_instret_hi;
            // Privileged group reads zero, writes are dropped without error
            csr_pkg::csr_satp,
            csr_pkg::csr_mstatus,
            csr_pkg::csr_medeleg,
            csr_pkg::csr_mideleg,
            csr_pkg::csr_mie,
            csr_pkg::csr_mtvec,
            csr_pkg::csr_mepc,
            csr_pkg::csr_pmpcfg0,
            csr_pkg::csr_pmpaddr0: begin
                sel_dec  = csr_pkg::sel_zero;
                writable = 1'b1;
            end
            default: ;
        endcase
    end

    assign access  = psel & penable;
    assign reject  = (sel_dec == csr_pkg::sel_none) | (pwrite & ~writable);
    assign pready  = access;
    assign pslverr = access & reject;

    // Rejected accesses select nothing so read data stays zero
    assign acc.sel   = reject ? csr_pkg::sel_none : sel_dec;
    assign acc.wr_en = access & setup_q & pwrite & ~reject;
    assign acc.wid   = pwid;
    assign acc.wdata = pwdata;

    // Previous cycle was an APB setup phase
    always_ff @(posedge clk) begin
        if (reset) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel & ~penable;
        end
    end

endmodule

`default_nettype wire

// ==== logic/csr_pkg.sv ====
// Data width is fixed at 32 bits; warp and thread counts must match wid_bits and masks
`default_nettype none

package csr_pkg;

    localparam int xlen        = 32;
    localparam int num_warps   = 4;
    localparam int num_threads = 4;
    localparam int wid_bits    = 2;
    localparam int addr_bits   = 12;
    localparam int ctr_bits    = 64;
    localparam int frm_bits    = 3;
    localparam int fflags_bits = 5;
    localparam int commit_bits = 3;

    // Floating-point user CSRs
    localparam logic [addr_bits-1:0] csr_fflags = 12'h001;
    localparam logic [addr_bits-1:0] csr_frm    = 12'h002;
    localparam logic [addr_bits-1:0] csr_fcsr   = 12'h003;

    // Machine CSRs
    localparam logic [addr_bits-1:0] csr_satp      = 12'h180;
    localparam logic [addr_bits-1:0] csr_mstatus   = 12'h300;
    localparam logic [addr_bits-1:0] csr_misa      = 12'h301;
    localparam logic [addr_bits-1:0] csr_medeleg   = 12'h302;
    localparam logic [addr_bits-1:0] csr_mideleg   = 12'h303;
    localparam logic [addr_bits-1:0] csr_mie       = 12'h304;
    localparam logic [addr_bits-1:0] csr_mtvec     = 12'h305;
    localparam logic [addr_bits-1:0] csr_mscratch  = 12'h340;
    localparam logic [addr_bits-1:0] csr_mepc      = 12'h341;
    localparam logic [addr_bits-1:0] csr_pmpcfg0   = 12'h3a0;
    localparam logic [addr_bits-1:0] csr_pmpaddr0  = 12'h3b0;
    localparam logic [addr_bits-1:0] csr_mcycle    = 12'hb00;
    localparam logic [addr_bits-1:0] csr_minstret  = 12'hb02;
    localparam logic [addr_bits-1:0] csr_mcycleh   = 12'hb80;
    localparam logic [addr_bits-1:0] csr_minstreth = 12'hb82;
    localparam logic [addr_bits-1:0] csr_mvendorid = 12'hf11;
    localparam logic [addr_bits-1:0] csr_marchid   = 12'hf12;
    localparam logic [addr_bits-1:0] csr_mimpid    = 12'hf13;

    // GPU identity CSRs
    localparam logic [addr_bits-1:0] csr_warp_id        = 12'hcc1;
    localparam logic [addr_bits-1:0] csr_core_id        = 12'hcc2;
    localparam logic [addr_bits-1:0] csr_active_warps   = 12'hcc3;
    localparam logic [addr_bits-1:0] csr_active_threads = 12'hcc4;
    localparam logic [addr_bits-1:0] csr_num_threads    = 12'hfc0;
    localparam logic [addr_bits-1:0] csr_num_warps      = 12'hfc1;

    localparam logic [xlen-1:0] vendor_id  = 32'h0000_0000;
    localparam logic [xlen-1:0] arch_id    = 32'h0000_0001;
    localparam logic [xlen-1:0] impl_id    = 32'h0000_0001;
    // RV32 with I, M and F
    localparam logic [xlen-1:0] misa_value = 32'h4000_1120;

    localparam int sel_bits = 5;

    localparam logic [sel_bits-1:0] sel_none           = 5'd0;
    localparam logic [sel_bits-1:0] sel_fflags         = 5'd1;
    localparam logic [sel_bits-1:0] sel_frm            = 5'd2;
    localparam logic [sel_bits-1:0] sel_fcsr           = 5'd3;
    localparam logic [sel_bits-1:0] sel_mscratch       = 5'd4;
    localparam logic [sel_bits-1:0] sel_mvendorid      = 5'd5;
    localparam logic [sel_bits-1:0] sel_marchid        = 5'd6;
    localparam logic [sel_bits-1:0] sel_mimpid         = 5'd7;
    localparam logic [sel_bits-1:0] sel_misa           = 5'd8;
    localparam logic [sel_bits-1:0] sel_warp_id        = 5'd9;
    localparam logic [sel_bits-1:0] sel_core_id        = 5'd10;
    localparam logic [sel_bits-1:0] sel_active_threads = 5'd11;
    localparam logic [sel_bits-1:0] sel_active_warps   = 5'd12;
    localparam logic [sel_bits-1:0] sel_num_threads    = 5'd13;
    localparam logic [sel_bits-1:0] sel_num_warps      = 5'd14;
    localparam logic [sel_bits-1:0] sel_cycle_lo       = 5'd15;
    localparam logic [sel_bits-1:0] sel_cycle_hi       = 5'd16;
    localparam logic [sel_bits-1:0] sel_instret_lo     = 5'd17;
    localparam logic [sel_bits-1:0] sel_instret_hi     = 5'd18;
    localparam logic [sel_bits-1:0] sel_zero           = 5'd19;

    typedef struct packed {
        logic [frm_bits-1:0]    frm;
        logic [fflags_bits-1:0] fflags;
    } fp_fields_t;

    // Same byte seen as the whole fcsr or as its two fields
    typedef union packed {
        logic [frm_bits+fflags_bits-1:0] fcsr;
        fp_fields_t                      fields;
    } fp_status_u;

endpackage

`default_nettype wire

// ==== logic/csr_read_mux.sv ====
// Combinational read path; unselected and zero-group registers return zero
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux #(
    parameter int core_id = 0
) (
    csr_access_if.read                                   acc,
    input  csr_pkg::fp_status_u [csr_pkg::num_warps-1:0] fp_status,
    input  logic [csr_pkg::xlen-1:0]                     mscratch,
    input  logic [csr_pkg::ctr_bits-1:0]                 cycle_count,
    input  logic [csr_pkg::ctr_bits-1:0]                 instret_count,
    input  logic [csr_pkg::num_warps-1:0]                active_warps,
    input  logic [csr_pkg::num_warps-1:0][csr_pkg::num_threads-1:0] thread_masks,
    output logic [csr_pkg::xlen-1:0]                     prdata
);

    csr_pkg::fp_status_u fp_sel;

    // Status word of the requesting warp
    assign fp_sel = fp_status[acc.wid];

    always_comb begin
        prdata = '0;
        case (acc.sel)
            csr_pkg::sel_fflags: begin
                prdata[csr_pkg::fflags_bits-1:0] = fp_sel.fields.fflags;
            end
            csr_pkg::sel_frm: begin
                prdata[csr_pkg::frm_bits-1:0] = fp_sel.fields.frm;
            end
            csr_pkg::sel_fcsr: begin
                prdata[csr_pkg::frm_bits+csr_pkg::fflags_bits-1:0] = fp_sel.fcsr;
            end
            csr_pkg::sel_mscratch:  prdata = mscratch;
            csr_pkg::sel_mvendorid: prdata = csr_pkg::vendor_id;
            csr_pkg::sel_marchid:   prdata = csr_pkg::arch_id;
            csr_pkg::sel_mimpid:    prdata = csr_pkg::impl_id;
            csr_pkg::sel_misa:      prdata = csr_pkg::misa_value;
            csr_pkg::sel_warp_id: begin
                prdata[csr_pkg::wid_bits-1:0] = acc.wid;
            end
            csr_pkg::sel_core_id:   prdata = core_id;
            csr_pkg::sel_active_threads: begin
                prdata[csr_pkg::num_threads-1:0] = thread_masks[acc.wid];
            end
            csr_pkg::sel_active_warps: begin
                prdata[csr_pkg::num_warps-1:0] = active_warps;
            end
            csr_pkg::sel_num_threads: prdata = csr_pkg::num_threads;
            csr_pkg::sel_num_warps:   prdata = csr_pkg::num_warps;
            // 64-bit counters as two halves
            csr_pkg::sel_cycle_lo: begin
                prdata = cycle_count[csr_pkg::xlen-1:0];
            end
            csr_pkg::sel_cycle_hi: begin
                prdata = cycle_count[csr_pkg::ctr_bits-1:csr_pkg::xlen];
            end
            csr_pkg::sel_instret_lo: begin
                prdata = instret_count[csr_pkg::xlen-1:0];
            end
            csr_pkg::sel_instret_hi: begin
                prdata = instret_count[csr_pkg::ctr_bits-1:csr_pkg::xlen];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/csr_state.sv ====
// One FPU flag port; a same-edge CSR write of the flags wins over the FPU report
`timescale 1ns/1ns
`default_nettype none

module csr_state (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [csr_pkg::xlen-1:0]        startup_arg,
    input  logic [csr_pkg::commit_bits-1:0] commit_count,
    input  logic                            fpu_flag_valid,
    input  logic [csr_pkg::wid_bits-1:0]    fpu_flag_wid,
    input  logic [csr_pkg::fflags_bits-1:0] fpu_fflags,
    input  logic [csr_pkg::wid_bits-1:0]    fpu_frm_wid,
    output logic [csr_pkg::frm_bits-1:0]    fpu_frm,
    csr_access_if.state                     acc,
    output csr_pkg::fp_status_u [csr_pkg::num_warps-1:0] fp_status,
    output logic [csr_pkg::xlen-1:0]        mscratch,
    output logic [csr_pkg::ctr_bits-1:0]    cycle_count,
    output logic [csr_pkg::ctr_bits-1:0]    instret_count
);

    csr_pkg::fp_status_u [csr_pkg::num_warps-1:0] fp_status_n;
    logic [csr_pkg::ctr_bits-1:0]                 commit_ext;

    assign commit_ext = {{(csr_pkg::ctr_bits - csr_pkg::commit_bits){1'b0}}, commit_count};

    always_comb begin
        fp_status_n = fp_status;

        // Accrue FPU exceptions first
        if (fpu_flag_valid) begin
            fp_status_n[fpu_flag_wid].fields.fflags =
                fp_status[fpu_flag_wid].fields.fflags | fpu_fflags;
        end

        // CSR write applied last so it overrides the accrued flags
        if (acc.wr_en) begin
            case (acc.sel)
                csr_pkg::sel_fflags: begin
                    fp_status_n[acc.wid].fields.fflags =
                        acc.wdata[csr_pkg::fflags_bits-1:0];
                end
                csr_pkg::sel_frm: begin
                    fp_status_n[acc.wid].fields.frm = acc.wdata[csr_pkg::frm_bits-1:0];
                end
                csr_pkg::sel_fcsr: begin
                    fp_status_n[acc.wid].fcsr =
                        acc.wdata[csr_pkg::frm_bits+csr_pkg::fflags_bits-1:0];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fp_status <= '0;
        end else begin
            fp_status <= fp_status_n;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= startup_arg;
        end else if (acc.wr_en && (acc.sel == csr_pkg::sel_mscratch)) begin
            mscratch <= acc.wdata;
        end
    end

    // Cycle reads zero in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else begin
            cycle_count   <= cycle_count + {{(csr_pkg::ctr_bits - 1){1'b0}}, 1'b1};
            instret_count <= instret_count + commit_ext;
        end
    end

    assign fpu_frm = fp_status[fpu_frm_wid].fields.frm;

endmodule

`default_nettype wire

// ==== logic/csr_unit.sv ====
// One core's CSR block behind a zero-wait APB slave; core_id must differ per core
`timescale 1ns/1ns
`default_nettype none

module csr_unit #(
    parameter int core_id = 0
) (
    input  logic                            clk,
    input  logic                            reset,

    // APB slave
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [csr_pkg::addr_bits-1:0]   paddr,
    input  logic [csr_pkg::xlen-1:0]        pwdata,
    input  logic [csr_pkg::wid_bits-1:0]    pwid,
    output logic [csr_pkg::xlen-1:0]        prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Core side
    input  logic [csr_pkg::xlen-1:0]        startup_arg,
    input  logic [csr_pkg::num_warps-1:0]   active_warps,
    input  logic [csr_pkg::num_warps-1:0][csr_pkg::num_threads-1:0] thread_masks,
    input  logic [csr_pkg::commit_bits-1:0] commit_count,

    // FPU flag report and rounding-mode lookup
    input  logic                            fpu_flag_valid,
    input  logic [csr_pkg::wid_bits-1:0]    fpu_flag_wid,
    input  logic [csr_pkg::fflags_bits-1:0] fpu_fflags,
    input  logic [csr_pkg::wid_bits-1:0]    fpu_frm_wid,
    output logic [csr_pkg::frm_bits-1:0]    fpu_frm
);

    csr_access_if acc ();

    csr_pkg::fp_status_u [csr_pkg::num_warps-1:0] fp_status;
    logic [csr_pkg::xlen-1:0]                     mscratch;
    logic [csr_pkg::ctr_bits-1:0]                 cycle_count;
    logic [csr_pkg::ctr_bits-1:0]                 instret_count;

    csr_addr_decode u_decode (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pwid    (pwid),
        .pready  (pready),
        .pslverr (pslverr),
        .acc     (acc.decode)
    );

    csr_state u_state (
        .clk            (clk),
        .reset          (reset),
        .startup_arg    (startup_arg),
        .commit_count   (commit_count),
        .fpu_flag_valid (fpu_flag_valid),
        .fpu_flag_wid   (fpu_flag_wid),
        .fpu_fflags     (fpu_fflags),
        .fpu_frm_wid    (fpu_frm_wid),
        .fpu_frm        (fpu_frm),
        .acc            (acc.state),
        .fp_status      (fp_status),
        .mscratch       (mscratch),
        .cycle_count    (cycle_count),
        .instret_count  (instret_count)
    );

    csr_read_mux #(
        .core_id (core_id)
    ) u_read_mux (
        .acc           (acc.read),
        .fp_status     (fp_status),
        .mscratch      (mscratch),
        .cycle_count   (cycle_count),
        .instret_count (instret_count),
        .active_warps  (active_warps),
        .thread_masks  (thread_masks),
        .prdata        (prdata)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
    -f vlog.f \
    --top-module csr_unit_tb \
    -o csr_unit_sim

./obj_dir/csr_unit_sim

// ==== tb/csr_unit_properties.sv ====
// Watches only the APB response of csr_unit; sampled on the rising clock edge outside reset
`timescale 1ns/1ns
`default_nettype none

module csr_unit_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     psel,
    input logic                     penable,
    input logic                     pready,
    input logic                     pslverr,
    input logic [csr_pkg::xlen-1:0] prdata
);

    // Zero-wait slave
    property ready_follows_access;
        @(posedge clk) disable iff (reset) pready == (psel && penable);
    endproperty

    property error_only_when_ready;
        @(posedge clk) disable iff (reset) pslverr |-> pready;
    endproperty

    property error_reads_zero;
        @(posedge clk) disable iff (reset) pslverr |-> (prdata == '0);
    endproperty

    ready_check: assert property (ready_follows_access)
        else $error("pready differs from psel and penable");

    error_ready_check: assert property (error_only_when_ready)
        else $error("pslverr raised outside an access cycle");

    error_data_check: assert property (error_reads_zero)
        else $error("prdata not zero with pslverr high: %h", prdata);

endmodule

bind csr_unit csr_unit_properties u_properties (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .prdata  (prdata)
);

`default_nettype wire

// ==== tb/csr_unit_tb.sv ====
// Runs the unit with core_id 3 and expects a zero-wait APB slave; stops at the first mismatch
`timescale 1ns/1ns
`default_nettype none

module csr_unit_tb;

    localparam int tb_core_id  = 3;
    localparam int ready_limit = 8;

    localparam logic [csr_pkg::addr_bits-1:0] id_addrs [10] = '{
        csr_pkg::csr_mvendorid, csr_pkg::csr_marchid, csr_pkg::csr_mimpid,
        csr_pkg::csr_misa, csr_pkg::csr_warp_id, csr_pkg::csr_core_id,
        csr_pkg::csr_active_threads, csr_pkg::csr_active_warps,
        csr_pkg::csr_num_threads, csr_pkg::csr_num_warps
    };
    localparam logic [csr_pkg::addr_bits-1:0] fp_addrs [3] = '{
        csr_pkg::csr_fflags, csr_pkg::csr_frm, csr_pkg::csr_fcsr
    };
    localparam logic [csr_pkg::addr_bits-1:0] ctr_addrs [4] = '{
        csr_pkg::csr_mcycle, csr_pkg::csr_mcycleh,
        csr_pkg::csr_minstret, csr_pkg::csr_minstreth
    };
    localparam logic [csr_pkg::addr_bits-1:0] zero_addrs [9] = '{
        csr_pkg::csr_satp, csr_pkg::csr_mstatus, csr_pkg::csr_medeleg,
        csr_pkg::csr_mideleg, csr_pkg::csr_mie, csr_pkg::csr_mtvec,
        csr_pkg::csr_mepc, csr_pkg::csr_pmpcfg0, csr_pkg::csr_pmpaddr0
    };

    logic                            clk;
    logic                            reset;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [csr_pkg::addr_bits-1:0]   paddr;
    logic [csr_pkg::xlen-1:0]        pwdata;
    logic [csr_pkg::wid_bits-1:0]    pwid;
    logic [csr_pkg::xlen-1:0]        prdata;
    logic                            pready;
    logic                            pslverr;
    logic [csr_pkg::xlen-1:0]        startup_arg;
    logic [csr_pkg::num_warps-1:0]   active_warps;
    logic [csr_pkg::num_warps-1:0][csr_pkg::num_threads-1:0] thread_masks;
    logic [csr_pkg::commit_bits-1:0] commit_count;
    logic                            fpu_flag_valid;
    logic [csr_pkg::wid_bits-1:0]    fpu_flag_wid;
    logic [csr_pkg::fflags_bits-1:0] fpu_fflags;
    logic [csr_pkg::wid_bits-1:0]    fpu_frm_wid;
    logic [csr_pkg::frm_bits-1:0]    fpu_frm;

    logic [31:0] rng;
    logic        flags_on;
    logic        same_edge_flags;

    // Reference model of the register state
    csr_pkg::fp_status_u          model_fp [csr_pkg::num_warps];
    logic [csr_pkg::xlen-1:0]     model_scratch;
    logic [csr_pkg::ctr_bits-1:0] model_cycle;
    logic [csr_pkg::ctr_bits-1:0] model_instret;
    logic                         model_setup;

    csr_unit #(
        .core_id (tb_core_id)
    ) dut (
        .clk            (clk),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .pwid           (pwid),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .startup_arg    (startup_arg),
        .active_warps   (active_warps),
        .thread_masks   (thread_masks),
        .commit_count   (commit_count),
        .fpu_flag_valid (fpu_flag_valid),
        .fpu_flag_wid   (fpu_flag_wid),
        .fpu_fflags     (fpu_fflags),
        .fpu_frm_wid    (fpu_frm_wid),
        .fpu_frm        (fpu_frm)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Expected response of one access from the model state before the edge
    function automatic void expected_access(
        input  logic [csr_pkg::addr_bits-1:0] addr,
        input  logic                          write,
        input  logic [csr_pkg::wid_bits-1:0]  wid,
        output logic [csr_pkg::xlen-1:0]      data,
        output logic                          err
    );
        logic known;
        logic writable;
        known = 1'b1;
        data  = '0;
        case (addr)
            csr_pkg::csr_fflags:         data = {27'd0, model_fp[wid].fields.fflags};
            csr_pkg::csr_frm:            data = {29'd0, model_fp[wid].fields.frm};
            csr_pkg::csr_fcsr:           data = {24'd0, model_fp[wid].fcsr};
            csr_pkg::csr_mscratch:       data = model_scratch;
            csr_pkg::csr_mvendorid:      data = csr_pkg::vendor_id;
            csr_pkg::csr_marchid:        data = csr_pkg::arch_id;
            csr_pkg::csr_mimpid:         data = csr_pkg::impl_id;
            csr_pkg::csr_misa:           data = csr_pkg::misa_value;
            csr_pkg::csr_warp_id:        data = {30'd0, wid};
            csr_pkg::csr_core_id:        data = 32'(tb_core_id);
            csr_pkg::csr_active_threads: data = {28'd0, thread_masks[wid]};
            csr_pkg::csr_active_warps:   data = {28'd0, active_warps};
            csr_pkg::csr_num_threads:    data = 32'(csr_pkg::num_threads);
            csr_pkg::csr_num_warps:      data = 32'(csr_pkg::num_warps);
            csr_pkg::csr_mcycle:         data = model_cycle[31:0];
            csr_pkg::csr_mcycleh:        data = model_cycle[63:32];
            csr_pkg::csr_minstret:       data = model_instret[31:0];
            csr_pkg::csr_minstreth:      data = model_instret[63:32];
            csr_pkg::csr_satp, csr_pkg::csr_mstatus, csr_pkg::csr_medeleg,
            csr_pkg::csr_mideleg, csr_pkg::csr_mie, csr_pkg::csr_mtvec,
            csr_pkg::csr_mepc, csr_pkg::csr_pmpcfg0, csr_pkg::csr_pmpaddr0: data = '0;
            default:                     known = 1'b0;
        endcase
        writable = (addr inside {csr_pkg::csr_fflags, csr_pkg::csr_frm, csr_pkg::csr_fcsr,
                                 csr_pkg::csr_mscratch, csr_pkg::csr_satp,
                                 csr_pkg::csr_mstatus, csr_pkg::csr_medeleg,
                                 csr_pkg::csr_mideleg, csr_pkg::csr_mie, csr_pkg::csr_mtvec,
                                 csr_pkg::csr_mepc, csr_pkg::csr_pmpcfg0,
                                 csr_pkg::csr_pmpaddr0});
        err = ~known | (write & ~writable);
        if (err) begin
            data = '0;
        end
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // Model update; flags accrue first so a same-edge write replaces them
    always @(posedge clk) begin : model_update
        logic [csr_pkg::xlen-1:0] unused_data;
        logic                     write_err;
        if (reset) begin
            for (int i = 0; i < csr_pkg::num_warps; i++) begin
                model_fp[i] = '0;
            end
            model_scratch = startup_arg;
            model_cycle   = '0;
            model_instret = '0;
            model_setup   = 1'b0;
        end else begin
            model_cycle   = model_cycle + 64'd1;
            model_instret = model_instret + {61'd0, commit_count};
            if (fpu_flag_valid) begin
                model_fp[fpu_flag_wid].fields.fflags =
                    model_fp[fpu_flag_wid].fields.fflags | fpu_fflags;
            end
            if (psel && penable && pwrite && model_setup) begin
                expected_access(paddr, 1'b1, pwid, unused_data, write_err);
                if (!write_err) begin
                    case (paddr)
                        csr_pkg::csr_fflags:   model_fp[pwid].fields.fflags = pwdata[4:0];
                        csr_pkg::csr_frm:      model_fp[pwid].fields.frm = pwdata[2:0];
                        csr_pkg::csr_fcsr:     model_fp[pwid].fcsr = pwdata[7:0];
                        csr_pkg::csr_mscratch: model_scratch = pwdata;
                        default: ;
                    endcase
                end
            end
            model_setup = psel && !penable;
        end
    end

    always @(negedge clk) begin : compare
        logic [csr_pkg::xlen-1:0] want_data;
        logic                     want_err;
        if (!reset) begin
            assert (fpu_frm == model_fp[fpu_frm_wid].fields.frm) else
                report_failure($sformatf("** Error: fpu_frm warp %h got %h expected %h",
                    fpu_frm_wid, fpu_frm, model_fp[fpu_frm_wid].fields.frm));
            if (psel && penable) begin
                expected_access(paddr, pwrite, pwid, want_data, want_err);
                assert (pslverr == want_err) else
                    report_failure($sformatf("** Error: pslverr addr %h got %h expected %h",
                        paddr, pslverr, want_err));
                if (!pwrite || want_err) begin
                    assert (prdata == want_data) else
                        report_failure($sformatf("** Error: prdata addr %h got %h expected %h",
                            paddr, prdata, want_data));
                end
            end
        end
    end

    // One clock with fresh core-side traffic
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        r = next_rand();
        commit_count   <= r[2:0];
        fpu_frm_wid    <= r[4:3];
        fpu_flag_wid   <= r[6:5];
        fpu_fflags     <= r[11:7];
        fpu_flag_valid <= flags_on & r[12];
    endtask

    task automatic apb_access(
        input logic [csr_pkg::addr_bits-1:0] addr,
        input logic                          write,
        input logic [csr_pkg::xlen-1:0]      wdata,
        input logic [csr_pkg::wid_bits-1:0]  wid
    );
        int waited;
        tick();
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        pwid    <= wid;
        tick();
        penable <= 1'b1;
        // FPU report to the accessed warp at the edge that ends the access
        if (same_edge_flags) begin
            fpu_flag_valid <= 1'b1;
            fpu_flag_wid   <= wid;
            fpu_fflags     <= '1;
        end
        waited = 0;
        @(negedge clk);
        while (!pready) begin
            if (waited == ready_limit) begin
                report_failure($sformatf("pready never came for address %h", addr));
            end
            tick();
            @(negedge clk);
            waited++;
        end
        tick();
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Random writes through the three views and reads of every view of every warp
    task automatic exercise_fp_status(input int rounds);
        logic [31:0] r;
        for (int n = 0; n < rounds; n++) begin
            r = next_rand();
            apb_access(fp_addrs[r[3:2] % 2'd3], 1'b1, next_rand(), r[1:0]);
            for (int w = 0; w < csr_pkg::num_warps; w++) begin
                foreach (fp_addrs[i]) begin
                    apb_access(fp_addrs[i], 1'b0, '0, 2'(w));
                end
            end
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        rng             = 32'hb603;
        flags_on        = 1'b0;
        same_edge_flags = 1'b0;
        r = next_rand();
        startup_arg <= r;
        r = next_rand();
        thread_masks   <= r[15:0];
        active_warps   <= r[19:16];
        reset          <= 1'b1;
        psel           <= 1'b0;
        penable        <= 1'b0;
        pwrite         <= 1'b0;
        paddr          <= '0;
        pwdata         <= '0;
        pwid           <= '0;
        commit_count   <= '0;
        fpu_flag_valid <= 1'b0;
        fpu_flag_wid   <= '0;
        fpu_fflags     <= '0;
        fpu_frm_wid    <= '0;
        repeat (5) tick();
        reset <= 1'b0;

        for (int w = 0; w < csr_pkg::num_warps; w++) begin
            foreach (id_addrs[i]) begin
                apb_access(id_addrs[i], 1'b0, '0, 2'(w));
            end
        end

        apb_access(csr_pkg::csr_mscratch, 1'b0, '0, 2'd0);
        repeat (8) begin
            r = next_rand();
            apb_access(csr_pkg::csr_mscratch, 1'b1, next_rand(), r[1:0]);
            apb_access(csr_pkg::csr_mscratch, 1'b0, '0, r[3:2]);
        end

        exercise_fp_status(20);
        // FPU flag reports now run alongside the CSR writes
        flags_on = 1'b1;
        exercise_fp_status(30);
        flags_on = 1'b0;

        // Every CSR write collides with a flag report to the same warp
        same_edge_flags = 1'b1;
        exercise_fp_status(10);
        same_edge_flags = 1'b0;

        repeat (6) begin
            foreach (ctr_addrs[i]) begin
                r = next_rand();
                apb_access(ctr_addrs[i], 1'b0, '0, r[1:0]);
            end
        end

        repeat (20) begin
            r = next_rand();
            apb_access(r[11:0], r[12], next_rand(), r[14:13]);
        end
        foreach (id_addrs[i]) begin
            apb_access(id_addrs[i], 1'b1, next_rand(), 2'd1);
        end
        foreach (ctr_addrs[i]) begin
            apb_access(ctr_addrs[i], 1'b1, next_rand(), 2'd2);
        end
        foreach (zero_addrs[i]) begin
            apb_access(zero_addrs[i], 1'b1, next_rand(), 2'd3);
            apb_access(zero_addrs[i], 1'b0, '0, 2'd3);
        end
        exercise_fp_status(2);
        apb_access(csr_pkg::csr_mscratch, 1'b0, '0, 2'd0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/csr_pkg.sv
logic/csr_access_if.sv
logic/csr_addr_decode.sv
logic/csr_state.sv
logic/csr_read_mux.sv
logic/csr_unit.sv
tb/csr_unit_properties.sv
tb/csr_unit_tb.sv
